/* verilog/board_macros.svh */
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// board clock in MHz
`define CLK_MHZ      100

// I2S framing
`define SCK_HALF     16     // clk cycles per sck half period
`define SLOT_BITS    32     // sck cycles per ws half
`define SAMPLE_BITS  24     // data bits in one slot

// display scan, kept short for simulation
`define SCAN_DIV     64

// push button indices
`define KEY_CLEAR    0      // clears the peak
`define KEY_FREEZE   1      // holds both displays

`endif

/* verilog/audio_pkg.sv */
`include "board_macros.svh"

package audio_pkg;

    // raw two's complement sample from the microphone
    typedef logic signed [`SAMPLE_BITS-1:0] sample_t;

    // absolute sample with the low 8 bits dropped
    typedef logic [15:0] magnitude_t;

    // one received left-channel word
    typedef struct packed {
        logic    valid;     // single clk pulse
        sample_t sample;
    } i2s_word_t;

    // meter behaviour
    typedef enum logic [1:0] {
        WAIT_FIRST,         // nothing seen since reset or clear
        TRACK,              // displays follow samples
        FROZEN              // samples ignored
    } meter_state_t;

endpackage

/* verilog/board_pkg.sv */
package board_pkg;

    // bar graph, bit 0 is the bottom LED
    typedef logic [15:0] led_t;

    // push buttons, active high at the module boundary
    typedef logic [4:0] key_t;

    // segment a in bit 0, lit when high
    typedef logic [6:0] seg_pattern_t;

    // one-hot, bit 0 selects the rightmost digit
    typedef logic [3:0] digit_sel_t;

    // everything the display pins need for one scan step
    typedef struct packed {
        seg_pattern_t seg;
        digit_sel_t   digit_sel;
    } panel_t;

endpackage

/* verilog/i2s_mic_receiver.sv */
`timescale 1ns/10ps
`include "board_macros.svh"

module i2s_mic_receiver
    import audio_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      sd,
    output logic      sck,
    output logic      ws,
    output i2s_word_t word
);

    localparam int DIV_W  = $clog2(`SCK_HALF);
    localparam int SLOT_W = $clog2(`SLOT_BITS);

    logic [DIV_W-1:0]        div_cnt;
    logic [SLOT_W-1:0]       bit_cnt;
    logic [`SAMPLE_BITS-1:0] shift_reg;
    logic                    word_valid;
    logic                    sck_edge;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    data_bit;
    logic                    last_bit;

    assign sck_edge = (div_cnt == DIV_W'(`SCK_HALF - 1));
    assign sck_rise = sck_edge && !sck;   // sck goes high on this clk
    assign sck_fall = sck_edge && sck;

    // one-bit delay after ws falls, then MSB first
    assign data_bit = !ws && (bit_cnt >= SLOT_W'(1))
                      && (bit_cnt <= SLOT_W'(`SAMPLE_BITS));
    assign last_bit = !ws && (bit_cnt == SLOT_W'(`SAMPLE_BITS));

    // sck prescaler
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (sck_edge) begin
            div_cnt <= '0;
            sck     <= ~sck;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // bit position in the slot, ws flips on falling sck only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end else if (sck_fall) begin
            if (bit_cnt == SLOT_W'(`SLOT_BITS - 1)) begin
                bit_cnt <= '0;
                ws      <= ~ws;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // sd is stable around rising sck
    always_ff @(posedge clk) begin
        if (sck_rise && data_bit) begin
            shift_reg <= {shift_reg[`SAMPLE_BITS-2:0], sd};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= sck_rise && last_bit;   // same edge as the final shift
        end
    end

    // shift_reg holds still until the next left slot
    assign word = '{valid: word_valid, sample: sample_t'(shift_reg)};

endmodule

/* verilog/tick_gen.sv */
`timescale 1ns/10ps
`include "board_macros.svh"

module tick_gen (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    localparam int CNT_W = $clog2(`SCAN_DIV);

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(`SCAN_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;             // one clk every SCAN_DIV
        end
    end

endmodule

/* verilog/meter_control.sv */
`timescale 1ns/10ps
`include "board_macros.svh"

module meter_control
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  i2s_word_t  word,
    input  key_t       key,
    output magnitude_t magnitude,
    output magnitude_t peak
);

    meter_state_t            state;
    meter_state_t            state_next;
    logic [`SAMPLE_BITS-1:0] abs_sample;
    magnitude_t              mag_new;
    logic                    clear_key;
    logic                    freeze_key;
    logic                    accept;

    assign clear_key  = key[`KEY_CLEAR];
    assign freeze_key = key[`KEY_FREEZE];

    // full-scale negative maps to 0x800000, still fits unsigned
    assign abs_sample = word.sample[`SAMPLE_BITS-1] ? (~word.sample + 1'b1)
                                                    : word.sample;
    assign mag_new    = abs_sample[`SAMPLE_BITS-1 -: $bits(magnitude_t)];

    assign accept = word.valid && (state != FROZEN);

    // clear has priority over freeze
    always_comb begin
        state_next = state;
        if (clear_key) begin
            state_next = WAIT_FIRST;
        end else if (freeze_key) begin
            state_next = FROZEN;
        end else begin
            case (state)
                WAIT_FIRST: begin
                    if (word.valid) begin
                        state_next = TRACK;
                    end
                end
                FROZEN:  state_next = TRACK;   // key released
                default: state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= WAIT_FIRST;
        end else begin
            state <= state_next;
        end
    end

    // the live level, held while frozen
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            magnitude <= '0;
        end else if (accept) begin
            magnitude <= mag_new;
        end
    end

    // first sample after a clear loads directly, afterwards keep the max
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            peak <= '0;
        end else if (clear_key) begin
            peak <= '0;
        end else if (accept && ((state == WAIT_FIRST) || (mag_new > peak))) begin
            peak <= mag_new;
        end
    end

endmodule

/* verilog/led_bargraph.sv */
`timescale 1ns/10ps

module led_bargraph
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  magnitude_t magnitude,
    output led_t       led
);

    led_t therm;

    // LED i lights when any magnitude bit at or above i is set,
    // so the bar reaches up to the highest set bit
    always_comb begin
        for (int i = 0; i < $bits(led_t); i++) begin
            therm[i] = |(magnitude >> i);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;            // all dark
        end else begin
            led <= therm;
        end
    end

endmodule

/* verilog/seven_seg_scan.sv */
`timescale 1ns/10ps

module seven_seg_scan
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tick,
    input  magnitude_t value,
    output panel_t     panel
);

    // gfedcba, lit when high
    function automatic seg_pattern_t hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'h3f;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5b;
            4'h3:    return 7'h4f;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6d;
            4'h6:    return 7'h7d;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7f;
            4'h9:    return 7'h6f;
            4'ha:    return 7'h77;
            4'hb:    return 7'h7c;   // lower case b
            4'hc:    return 7'h39;
            4'hd:    return 7'h5e;   // lower case d
            4'he:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    digit_sel_t sel_next;
    logic [3:0] nibble;

    assign sel_next = {panel.digit_sel[2:0], panel.digit_sel[3]};   // rotate left

    // nibble for the digit about to be shown
    always_comb begin
        case (sel_next)
            4'b0010: nibble = value[7:4];
            4'b0100: nibble = value[11:8];
            4'b1000: nibble = value[15:12];
            default: nibble = value[3:0];
        endcase
    end

    // segments and select change on the same clk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            panel <= '{seg: hex_to_seg(4'h0), digit_sel: 4'b0001};
        end else if (tick) begin
            panel <= '{seg: hex_to_seg(nibble), digit_sel: sel_next};
        end
    end

endmodule

/* verilog/board_specific_top.sv */
`timescale 1ns/10ps

module board_specific_top
    import audio_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  key_t       key,
    input  logic       sd,
    output logic       sck,
    output logic       ws,
    output logic       lr,
    output led_t       led,
    output logic [6:0] seg,
    output logic [3:0] an
);

    i2s_word_t  word;
    magnitude_t magnitude;
    magnitude_t peak;
    logic       scan_tick;
    panel_t     panel;

    i2s_mic_receiver i_microphone (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .sd     ( sd     ),
        .sck    ( sck    ),
        .ws     ( ws     ),
        .word   ( word   )
    );

    tick_gen i_scan_tick (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .tick   ( scan_tick )
    );

    meter_control i_meter (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .word      ( word      ),
        .key       ( key       ),
        .magnitude ( magnitude ),
        .peak      ( peak      )
    );

    led_bargraph i_bargraph (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .magnitude ( magnitude ),
        .led       ( led       )
    );

    seven_seg_scan i_display (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .tick   ( scan_tick ),
        .value  ( peak      ),
        .panel  ( panel     )
    );

    assign seg = ~panel.seg;        // common anode board
    assign an  = ~panel.digit_sel;
    assign lr  = 1'b0;              // left channel

endmodule

/* tests/board_assertions.sv */
`timescale 1ns/10ps

module board_assertions
    import board_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       sck,
    input logic       ws,
    input logic [3:0] an,
    input led_t       led
);

    int fail_count = 0;     // number of failed assertions

    // exactly one anode pulled low
    a_one_digit: assert property (@(posedge clk) disable iff (!arst_n) $onehot(~an))
        else begin
            $error("digit select is not one-hot low: %b", an);
            fail_count++;
        end

    // bar must fill from bit 0 with no gaps
    a_thermometer: assert property (@(posedge clk) disable iff (!arst_n)
        (({1'b0, led} + 17'd1) & {1'b0, led}) == 17'd0)
        else begin
            $error("led pattern %h is not a bar", led);
            fail_count++;
        end

    a_ws_on_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(ws) |-> $fell(sck))
        else begin
            $error("ws changed without a falling sck");
            fail_count++;
        end

    // clocks to the microphone stay quiet in reset
    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (!sck && !ws))
        else begin
            $error("sck or ws high during reset");
            fail_count++;
        end

endmodule

bind board_specific_top board_assertions i_board_assertions (
    .clk    ( clk    ),
    .arst_n ( arst_n ),
    .sck    ( sck    ),
    .ws     ( ws     ),
    .an     ( an     ),
    .led    ( led    )
);

/* tests/tb_board_top.sv */
`timescale 1ns/10ps
`include "board_macros.svh"

module tb_board_top
    import audio_pkg::*;
    import board_pkg::*;
;

    localparam int FRAME_CLKS = 2 * `SLOT_BITS * 2 * `SCK_HALF;
    localparam int N_FRAMES   = 51;

    // standard hex patterns in gfedcba order
    localparam seg_pattern_t SEG_TABLE [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
        7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

    logic       clk;
    logic       arst_n;
    key_t       key;
    logic       sd;
    logic       sck;
    logic       ws;
    logic       lr;
    led_t       led;
    logic [6:0] seg;
    logic [3:0] an;

    logic [31:0]  lfsr = 32'h3e7bf019;
    magnitude_t   model_mag = '0;
    magnitude_t   model_peak = '0;
    meter_state_t model_state = WAIT_FIRST;

    board_specific_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function automatic led_t thermometer(input magnitude_t m);
        led_t t;
        t = '0;
        for (int i = 0; i < 16; i++) begin
            if (m[i]) t = led_t'((17'd1 << (i + 1)) - 17'd1);
        end
        return t;
    endfunction

    task automatic fail_now();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_led(input string name, input led_t exp, input led_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_digit(input string name, input seg_pattern_t exp,
                               input seg_pattern_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            fail_now();
        end
    endtask

    // key rules as seen when the keys change
    task automatic apply_keys(input key_t k);
        if (k[`KEY_CLEAR]) begin
            model_state = WAIT_FIRST;
            model_peak  = '0;
        end else if (k[`KEY_FREEZE]) begin
            model_state = FROZEN;
        end else if (model_state == FROZEN) begin
            model_state = TRACK;
        end
    endtask

    task automatic process_word(input logic [23:0] w);
        int         s;
        magnitude_t m;
        s = int'($signed(w));
        if (s < 0) s = -s;
        m = magnitude_t'(s >> 8);
        if (model_state == FROZEN) return;
        model_mag = m;
        if (key[`KEY_CLEAR]) return;   // peak pinned at zero
        if (model_state == WAIT_FIRST || m > model_peak) model_peak = m;
        model_state = TRACK;
    endtask

    // microphone model driving sd after each falling sck
    initial begin
        int          pos;
        int          word_idx;
        logic        prev_ws;
        logic        b;
        logic [23:0] cur;
        logic [23:0] forced;
        pos = 0;
        word_idx = 0;
        prev_ws = 1'b0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge sck);
            #2;
            if (ws !== prev_ws) begin
                pos = 0;
                prev_ws = ws;
            end else begin
                pos++;
            end
            forced = (word_idx == 6) ? 24'h7fffff : (word_idx == 7) ? 24'h800000 : 24'h0;
            if (!ws && pos >= 1 && pos <= 24 && word_idx >= 5 && word_idx <= 7) begin
                b = forced[24 - pos];
            end else begin
                b = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            sd = b;
            if (!ws && pos >= 1 && pos <= 24) cur = {cur[22:0], b};
            if (!ws && pos == 24) begin
                process_word(cur);
                word_idx++;
            end
        end
    end

    task automatic check_digits(input string name);
        int idx;
        repeat (4) begin
            @(an);
            #1;
            idx = 0;
            for (int i = 0; i < 4; i++) begin
                if (!an[i]) idx = i;
            end
            check_digit(name, SEG_TABLE[model_peak[idx*4 +: 4]], seg_pattern_t'(~seg));
        end
    endtask

    task automatic run_frame(input string name, input key_t k);
        @(negedge ws);
        #2;
        check_led(name, thermometer(model_mag), led);
        key = k;
        apply_keys(k);
        repeat (2) @(posedge clk);
        check_digits(name);
    endtask

    initial begin
        #((N_FRAMES + 4) * FRAME_CLKS * 20);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    // a failed assertion in the bound checker ends the run
    initial begin
        wait (UUT.i_board_assertions.fail_count != 0);
        $display("an assertion in the bound checker failed");
        $display("*** TEST FAILED ***");
        $fatal(1, "assertion failure");
    end

    initial begin
        key_t k;
        arst_n = 1'b0;
        key = '0;
        sd = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        check_led("reset led", '0, led);
        check_pin("reset sck", 1'b0, sck);
        check_pin("reset ws", 1'b0, ws);
        check_pin("reset lr", 1'b0, lr);
        check_pin("reset digit 0", 1'b0, an[0]);
        check_digit("reset seg", SEG_TABLE[0], seg_pattern_t'(~seg));
        arst_n = 1'b1;
        @(posedge clk);
        #2;
        check_led("after reset led", '0, led);
        check_pin("after reset sck", 1'b0, sck);
        check_pin("after reset lr", 1'b0, lr);

        for (int i = 0; i < 40; i++) run_frame($sformatf("bargraph frame %0d", i), '0);
        k = '0;
        k[`KEY_FREEZE] = 1'b1;
        for (int i = 0; i < 4; i++) run_frame($sformatf("freeze frame %0d", i), k);
        for (int i = 0; i < 3; i++) run_frame($sformatf("release frame %0d", i), '0);
        k = '0;
        k[`KEY_CLEAR] = 1'b1;
        run_frame("clear frame", k);
        for (int i = 0; i < 3; i++) run_frame($sformatf("after clear frame %0d", i), '0);

        if (UUT.i_board_assertions.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+verilog
verilog/audio_pkg.sv
verilog/board_pkg.sv
verilog/i2s_mic_receiver.sv
verilog/tick_gen.sv
verilog/meter_control.sv
verilog/led_bargraph.sv
verilog/seven_seg_scan.sv
verilog/board_specific_top.sv
tests/board_assertions.sv
tests/tb_board_top.sv
